/* vlog.f */
+incdir+.
csr_pkg.sv
csr_decode.sv
csr_execute.sv
csr_machine_regs.sv
csr_perf_counters.sv
csr_result.sv
csr_top.sv
tb_csr_top.sv

/* run.sh */
#!/usr/bin/env bash
# build the csr testbench with verilator, run it, check the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_csr_top \
  -f vlog.f -o sim_csr > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_csr > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log

grep -q "RESULT: PASS" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* tb_csr_top.sv */
`timescale 1ns/1ps
`include "csr_settings.svh"

module tb_csr_top import csr_pkg::*; ();

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 10;
  localparam int MAX_CYCLES   = 2000;
  localparam int WRAP_TIMEOUT = 40;
  localparam int N_RANDOM     = 48;
  localparam int N_EV_CYCLES  = 24;

  // registers read right after reset
  localparam logic [11:0] RESET_READS [7] = '{
    `CSR_ADDR_MSTATUS, `CSR_ADDR_MEPC, `CSR_ADDR_MCAUSE, `CSR_ADDR_PCER,
    `CSR_ADDR_PCMR, `CSR_ADDR_MTVEC, `CSR_ADDR_MHARTID
  };
  // holes in the address map
  localparam logic [11:0] UNMAPPED [4] = '{12'h7B0, 12'h344, 12'hF15, 12'h301};

  logic                 clk;
  logic                 rst_n;
  csr_req_t             req;
  trap_ctrl_t           trap;
  perf_events_t         ev;
  logic [23:0]          boot_addr;
  logic [3:0]           core_id;
  logic [5:0]           cluster_id;
  logic [`CSR_XLEN-1:0] rdata;
  logic [`CSR_XLEN-1:0] epc;
  logic                 irq_enable;

  // shadow model of the state after the next rising edge
  logic                 m_mie;
  logic                 m_mpie;
  logic [`CSR_XLEN-1:0] m_mepc;
  logic                 m_irq;
  logic [4:0]           m_code;
  logic [7:0]           m_pcer;
  logic [1:0]           m_pcmr;

  // expected outputs for the current cycle
  logic [`CSR_XLEN-1:0] exp_rdata;
  logic [`CSR_XLEN-1:0] exp_epc;
  logic                 exp_irq;
  logic                 chk_rdata;
  logic                 chk_below16;

  int                   mismatch_cnt;
  int                   other_err_cnt;
  logic [15:0]          lfsr_q;

  csr_top csr_top_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_i        (req),
    .trap_i       (trap),
    .ev_i         (ev),
    .boot_addr_i  (boot_addr),
    .core_id_i    (core_id),
    .cluster_id_i (cluster_id),
    .rdata_o      (rdata),
    .epc_o        (epc),
    .irq_enable_o (irq_enable)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // random source
  ////////////////////////////////////////////////////////////

  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // one lfsr step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  function automatic logic is_counter_addr(input logic [11:0] addr);
    return (addr - `CSR_ADDR_PCCR_BASE) < 12'd8;
  endfunction

  // counter reads are checked by their callers
  function automatic logic [31:0] expected_read(input logic [11:0] addr);
    logic [31:0] v;
    v = '0;
    case (addr)
      `CSR_ADDR_MSTATUS: begin
        // mpp fixed at machine mode
        v = 32'h0000_1800;
        v[`CSR_MSTATUS_MIE_BIT]  = m_mie;
        v[`CSR_MSTATUS_MPIE_BIT] = m_mpie;
      end
      `CSR_ADDR_MTVEC:   v = {boot_addr, 8'h00};
      `CSR_ADDR_MEPC:    v = m_mepc;
      `CSR_ADDR_MCAUSE: begin
        v[31]  = m_irq;
        v[4:0] = m_code;
      end
      `CSR_ADDR_MHARTID: begin
        v[10:5] = cluster_id;
        v[3:0]  = core_id;
      end
      `CSR_ADDR_PCER:    v[7:0] = m_pcer;
      `CSR_ADDR_PCMR:    v[1:0] = m_pcmr;
      default:           v = '0;
    endcase
    return v;
  endfunction

  function automatic void update_model(input csr_req_t r, input trap_ctrl_t t,
                                       input logic [31:0] old);
    logic [31:0] nw;
    logic        mie_old;
    logic        mpie_old;
    // trap and mret see the register values from before this edge
    mie_old  = m_mie;
    mpie_old = m_mpie;
    nw = r.wdata;
    if (r.op == CSR_OP_SET) nw = old | r.wdata;
    if (r.op == CSR_OP_CLEAR) nw = old & ~r.wdata;
    if (r.access && r.op != CSR_OP_NONE) begin
      case (r.addr)
        `CSR_ADDR_MSTATUS: begin
          m_mie  = nw[`CSR_MSTATUS_MIE_BIT];
          m_mpie = nw[`CSR_MSTATUS_MPIE_BIT];
        end
        `CSR_ADDR_MEPC:   m_mepc = nw;
        `CSR_ADDR_MCAUSE: begin
          m_irq  = nw[31];
          m_code = nw[4:0];
        end
        `CSR_ADDR_PCER:   m_pcer = nw[7:0];
        `CSR_ADDR_PCMR:   m_pcmr = nw[1:0];
        default: ;
      endcase
    end
    // trap entry overrides a write in the same cycle
    if (t.save_cause) begin
      m_mepc = t.save_if ? t.pc_if : t.pc_id;
      m_irq  = t.cause[5];
      m_code = t.cause[4:0];
      m_mpie = mie_old;
      m_mie  = 1'b0;
    end else if (t.restore_mret) begin
      m_mie  = mpie_old;
      m_mpie = 1'b1;
    end
  endfunction

  ////////////////////////////////////////////////////////////
  // drivers
  ////////////////////////////////////////////////////////////

  task automatic drive_cycle(input csr_req_t r, input trap_ctrl_t t, input perf_events_t e);
    logic [31:0] old;
    @(negedge clk);
    // what the last rising edge left behind
    exp_epc = m_mepc;
    exp_irq = m_mie;
    req  = r;
    trap = t;
    ev   = e;
    old = r.access ? expected_read(r.addr) : '0;
    exp_rdata   = old;
    chk_rdata   = !r.access || !is_counter_addr(r.addr);
    chk_below16 = 1'b0;
    update_model(r, t, old);
  endtask

  task automatic csr_access(input logic [11:0] addr, input csr_op_e op,
                            input logic [31:0] wdata);
    csr_req_t r;
    r.access = 1'b1;
    r.addr   = addr;
    r.op     = op;
    r.wdata  = wdata;
    drive_cycle(r, '0, '0);
  endtask

  task automatic idle_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      drive_cycle('0, '0, '0);
    end
  endtask

  task automatic read_counter(input int idx, input logic [31:0] expected);
    csr_access(`CSR_ADDR_PCCR_BASE | 12'(idx), CSR_OP_NONE, '0);
    exp_rdata = expected;
    chk_rdata = 1'b1;
  endtask

  // trap plus a competing mepc write
  task automatic enter_trap(input logic from_if);
    csr_req_t   r;
    trap_ctrl_t t;
    t            = '0;
    t.save_cause = 1'b1;
    t.save_if    = from_if;
    t.save_id    = !from_if;
    t.cause      = 6'(take_bits(6));
    t.pc_if      = take_bits(32);
    t.pc_id      = take_bits(32);
    r.access     = 1'b1;
    r.addr       = `CSR_ADDR_MEPC;
    r.op         = CSR_OP_WRITE;
    r.wdata      = take_bits(32);
    drive_cycle(r, t, '0);
  endtask

  task automatic return_from_trap();
    trap_ctrl_t t;
    t              = '0;
    t.restore_mret = 1'b1;
    drive_cycle('0, t, '0);
  endtask

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  a_rdata: assert property (
    @(posedge clk) disable iff (!rst_n)
    chk_rdata |-> (rdata == exp_rdata)
  ) else begin
    mismatch_cnt = mismatch_cnt + 1;
    $display("Mismatch rdata_o: got %h, expected %h", $sampled(rdata), $sampled(exp_rdata));
  end

  a_epc: assert property (
    @(posedge clk) disable iff (!rst_n)
    epc == exp_epc
  ) else begin
    mismatch_cnt = mismatch_cnt + 1;
    $display("Mismatch epc_o: got %h, expected %h", $sampled(epc), $sampled(exp_epc));
  end

  a_irq: assert property (
    @(posedge clk) disable iff (!rst_n)
    irq_enable == exp_irq
  ) else begin
    mismatch_cnt = mismatch_cnt + 1;
    $display("Mismatch irq_enable_o: got %h, expected %h",
             $sampled(irq_enable), $sampled(exp_irq));
  end

  // a wrapped counter only has to read below 16
  a_below16: assert property (
    @(posedge clk) disable iff (!rst_n)
    chk_below16 |-> (rdata < 32'h10)
  ) else begin
    mismatch_cnt = mismatch_cnt + 1;
    $display("Mismatch rdata_o: got %h, expected below 00000010", $sampled(rdata));
  end

  initial begin : watchdog
    for (int c = 0; c < MAX_CYCLES; c++) begin
      @(posedge clk);
    end
    $display("timeout, run did not finish within %0d cycles", MAX_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  initial begin : stimulus
    logic [11:0]  addr;
    csr_op_e      op;
    perf_events_t e;
    int           n_loads;
    logic         wrapped;

    lfsr_q        = 16'd59796;
    rst_n         = 1'b0;
    req           = '0;
    trap          = '0;
    ev            = '0;
    boot_addr     = 24'(take_bits(24));
    core_id       = 4'(take_bits(4));
    cluster_id    = 6'(take_bits(6));
    m_mie         = 1'b0;
    m_mpie        = 1'b0;
    m_mepc        = '0;
    m_irq         = 1'b0;
    m_code        = '0;
    m_pcer        = '0;
    m_pcmr        = 2'b11;
    exp_rdata     = '0;
    exp_epc       = '0;
    exp_irq       = 1'b0;
    chk_rdata     = 1'b0;
    chk_below16   = 1'b0;
    mismatch_cnt  = 0;
    other_err_cnt = 0;

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // reset values, fixed ids and boot vector
    foreach (RESET_READS[i]) begin
      csr_access(RESET_READS[i], CSR_OP_NONE, '0);
    end

    // random ops each followed by a read back
    for (int i = 0; i < N_RANDOM; i++) begin
      case (take_bits(2))
        0:       addr = `CSR_ADDR_MEPC;
        1:       addr = `CSR_ADDR_MCAUSE;
        default: addr = `CSR_ADDR_MSTATUS;
      endcase
      op = csr_op_e'(2'(take_bits(2)));
      if (op == CSR_OP_NONE) op = CSR_OP_WRITE;
      csr_access(addr, op, take_bits(32));
      csr_access(addr, CSR_OP_NONE, '0);
    end

    // trap from fetch, mret, trap from decode, mret
    csr_access(`CSR_ADDR_MSTATUS, CSR_OP_SET, 32'h1 << `CSR_MSTATUS_MIE_BIT);
    for (int i = 0; i < 2; i++) begin
      enter_trap(i == 0);
      csr_access(`CSR_ADDR_MEPC, CSR_OP_NONE, '0);
      csr_access(`CSR_ADDR_MCAUSE, CSR_OP_NONE, '0);
      csr_access(`CSR_ADDR_MSTATUS, CSR_OP_NONE, '0);
      return_from_trap();
      csr_access(`CSR_ADDR_MSTATUS, CSR_OP_NONE, '0);
    end

    // only the load counter enabled
    csr_access(`CSR_ADDR_PCER, CSR_OP_WRITE, 32'h08);
    n_loads = 0;
    for (int i = 0; i < N_EV_CYCLES; i++) begin
      e           = '0;
      e.mem_load  = 1'(take_bits(1));
      e.mem_store = 1'(take_bits(1));
      e.id_valid  = 1'(take_bits(1));
      e.branch    = 1'(take_bits(1));
      if (e.mem_load) n_loads++;
      drive_cycle('0, '0, e);
    end
    idle_cycles(2);
    read_counter(3, 32'(n_loads));
    read_counter(4, '0);

    // saturate at all ones
    csr_access(`CSR_ADDR_PCMR, CSR_OP_WRITE, 32'h3);
    csr_access(`CSR_ADDR_PCCR_BASE, CSR_OP_WRITE, 32'hFFFF_FFFF);
    csr_access(`CSR_ADDR_PCER, CSR_OP_SET, 32'h01);
    idle_cycles(6);
    read_counter(0, 32'hFFFF_FFFF);
    csr_access(`CSR_ADDR_PCER, CSR_OP_NONE, '0);

    // in wrap mode poll until the cycle counter rolls over
    csr_access(`CSR_ADDR_PCMR, CSR_OP_WRITE, 32'h1);
    wrapped = 1'b0;
    for (int i = 0; i < WRAP_TIMEOUT && !wrapped; i++) begin
      csr_access(`CSR_ADDR_PCCR_BASE, CSR_OP_NONE, '0);
      #1;
      if (rdata < 32'h10) wrapped = 1'b1;
    end
    if (!wrapped) begin
      other_err_cnt++;
      $display("counter 0 did not wrap within %0d cycles", WRAP_TIMEOUT);
    end
    csr_access(`CSR_ADDR_PCCR_BASE, CSR_OP_NONE, '0);
    chk_below16 = 1'b1;

    // holes read zero and ignore writes
    foreach (UNMAPPED[i]) begin
      csr_access(UNMAPPED[i], CSR_OP_NONE, '0);
      csr_access(UNMAPPED[i], CSR_OP_WRITE, take_bits(32));
      csr_access(UNMAPPED[i], CSR_OP_SET, take_bits(32));
    end
    for (int i = 0; i < 5; i++) begin
      csr_access(RESET_READS[i], CSR_OP_NONE, '0);
    end

    idle_cycles(2);
    // let the last edge be checked
    @(negedge clk);

    $display("errors: %0d mismatches, %0d other", mismatch_cnt, other_err_cnt);
    if (mismatch_cnt == 0 && other_err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* csr_top.sv */
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_top import csr_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  csr_req_t             req_i,
  input  trap_ctrl_t           trap_i,
  input  perf_events_t         ev_i,
  input  logic [23:0]          boot_addr_i,
  input  logic [3:0]           core_id_i,
  input  logic [5:0]           cluster_id_i,
  output logic [`CSR_XLEN-1:0] rdata_o,
  output logic [`CSR_XLEN-1:0] epc_o,
  output logic                 irq_enable_o
);

  csr_sel_t               sel;
  csr_word_u              wword;
  logic                   we;
  mstatus_t               mstatus;
  logic [`CSR_XLEN-1:0]   mepc;
  mcause_t                mcause;
  logic [`CSR_N_PERF-1:0] pcer;
  logic [1:0]             pcmr;
  pccr_arr_t              pccr;

  csr_decode csr_decode_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .req_i (req_i),
    .sel_o (sel)
  );

  // read data doubles as the old value for set and clear
  csr_execute csr_execute_inst (
    .req_i   (req_i),
    .old_i   (rdata_o),
    .wword_o (wword),
    .we_o    (we)
  );

  csr_machine_regs csr_machine_regs_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .sel_i        (sel),
    .we_i         (we),
    .wword_i      (wword),
    .trap_i       (trap_i),
    .mstatus_o    (mstatus),
    .mepc_o       (mepc),
    .mcause_o     (mcause),
    .epc_o        (epc_o),
    .irq_enable_o (irq_enable_o)
  );

  csr_perf_counters csr_perf_counters_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .sel_i   (sel),
    .we_i    (we),
    .wword_i (wword),
    .ev_i    (ev_i),
    .pcer_o  (pcer),
    .pcmr_o  (pcmr),
    .pccr_o  (pccr)
  );

  csr_result csr_result_inst (
    .sel_i        (sel),
    .boot_addr_i  (boot_addr_i),
    .core_id_i    (core_id_i),
    .cluster_id_i (cluster_id_i),
    .mstatus_i    (mstatus),
    .mepc_i       (mepc),
    .mcause_i     (mcause),
    .pcer_i       (pcer),
    .pcmr_i       (pcmr),
    .pccr_i       (pccr),
    .rdata_o      (rdata_o)
  );

endmodule

/* csr_result.sv */
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_result import csr_pkg::*; (
  input  csr_sel_t               sel_i,
  input  logic [23:0]            boot_addr_i,
  input  logic [3:0]             core_id_i,
  input  logic [5:0]             cluster_id_i,
  input  mstatus_t               mstatus_i,
  input  logic [`CSR_XLEN-1:0]   mepc_i,
  input  mcause_t                mcause_i,
  input  logic [`CSR_N_PERF-1:0] pcer_i,
  input  logic [1:0]             pcmr_i,
  input  pccr_arr_t              pccr_i,
  output logic [`CSR_XLEN-1:0]   rdata_o
);

  // selects are one-hot, unmapped reads fall out as zero
  always_comb begin
    rdata_o = '0;
    if (sel_i.mstatus) rdata_o = mstatus_i;
    if (sel_i.mepc)    rdata_o = mepc_i;
    if (sel_i.mcause)  rdata_o = mcause_i;
    // trap vector fixed at the boot address
    if (sel_i.mtvec)   rdata_o = {boot_addr_i, 8'h00};
    // cluster in 10:5, core in 3:0
    if (sel_i.mhartid) rdata_o = {21'b0, cluster_id_i, 1'b0, core_id_i};
    if (sel_i.pcer)    rdata_o = `CSR_XLEN'(pcer_i);
    if (sel_i.pcmr)    rdata_o = `CSR_XLEN'(pcmr_i);
    if (sel_i.pccr)    rdata_o = pccr_i[sel_i.pccr_idx];
  end

endmodule

/* csr_perf_counters.sv */
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_perf_counters import csr_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  csr_sel_t               sel_i,
  input  logic                   we_i,
  input  csr_word_u              wword_i,
  input  perf_events_t           ev_i,
  output logic [`CSR_N_PERF-1:0] pcer_o,
  output logic [1:0]             pcmr_o,
  output pccr_arr_t              pccr_o
);

  logic                   id_valid_q;
  logic [`CSR_N_PERF-1:0] ev_cond;
  logic [`CSR_N_PERF-1:0] inc;
  logic [`CSR_N_PERF-1:0] inc_q;
  logic [`CSR_N_PERF-1:0] cnt_wr;
  logic [`CSR_N_PERF-1:0] pcer_q;
  // bit 0 global enable, bit 1 saturate
  logic [1:0]             pcmr_q;
  pccr_arr_t              cnt_q;
  pccr_arr_t              cnt_d;

  ////////////////////////////////////////////////////////////
  // event conditioning
  ////////////////////////////////////////////////////////////

  // cycles
  assign ev_cond[0] = 1'b1;
  // retired instructions
  assign ev_cond[1] = ev_i.id_valid & ev_i.is_decoding;
  // load use hazards, qualified by the previous id handshake
  assign ev_cond[2] = ev_i.ld_stall & id_valid_q;
  assign ev_cond[3] = ev_i.mem_load;
  assign ev_cond[4] = ev_i.mem_store;
  assign ev_cond[5] = ev_i.jump & id_valid_q;
  assign ev_cond[6] = ev_i.branch & id_valid_q;
  assign ev_cond[7] = ev_i.branch & ev_i.branch_taken & id_valid_q;

  assign inc = ev_cond & pcer_q & {`CSR_N_PERF{pcmr_q[0]}};

  ////////////////////////////////////////////////////////////
  // counters
  ////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < `CSR_N_PERF; i++) begin
      cnt_wr[i] = we_i && sel_i.pccr && (sel_i.pccr_idx == CSR_PERF_IDX_W'(i));
      cnt_d[i]  = cnt_q[i];
      // hold at all ones in saturate mode
      if (inc_q[i] && (!(&cnt_q[i]) || !pcmr_q[1])) begin
        cnt_d[i] = cnt_q[i] + 1'b1;
      end
      // a write beats a pending increment
      if (cnt_wr[i]) begin
        cnt_d[i] = wword_i.raw;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_q <= 1'b0;
      inc_q      <= '0;
      pcer_q     <= '0;
      pcmr_q     <= 2'b11;
      cnt_q      <= '0;
    end else begin
      id_valid_q <= ev_i.id_valid;
      inc_q      <= inc;
      cnt_q      <= cnt_d;
      if (we_i && sel_i.pcer) begin
        pcer_q <= wword_i.raw[`CSR_N_PERF-1:0];
      end
      if (we_i && sel_i.pcmr) begin
        pcmr_q <= wword_i.raw[1:0];
      end
    end
  end

  assign pcer_o = pcer_q;
  assign pcmr_o = pcmr_q;
  assign pccr_o = cnt_q;

  // saturating counter at all ones must not roll over
  for (genvar g = 0; g < `CSR_N_PERF; g++) begin : g_sat_chk
    a_sat_hold: assert property (
      @(posedge clk) disable iff (!rst_n)
      (pcmr_q[1] && (&cnt_q[g]) && !cnt_wr[g]) |=> (cnt_q[g] != '0)
    );
  end

endmodule

/* csr_machine_regs.sv */
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_machine_regs import csr_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  csr_sel_t             sel_i,
  input  logic                 we_i,
  input  csr_word_u            wword_i,
  input  trap_ctrl_t           trap_i,
  output mstatus_t             mstatus_o,
  output logic [`CSR_XLEN-1:0] mepc_o,
  output mcause_t              mcause_o,
  output logic [`CSR_XLEN-1:0] epc_o,
  output logic                 irq_enable_o
);

  // machine mode only, mpp never changes
  localparam logic [1:0] PRIV_M = 2'b11;

  logic                 mie_q;
  logic                 mie_d;
  logic                 mpie_q;
  logic                 mpie_d;
  logic [`CSR_XLEN-1:0] mepc_q;
  logic [`CSR_XLEN-1:0] mepc_d;
  // {irq, code}
  logic [5:0]           cause_q;
  logic [5:0]           cause_d;

  ////////////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////////////

  always_comb begin
    mie_d   = mie_q;
    mpie_d  = mpie_q;
    mepc_d  = mepc_q;
    cause_d = cause_q;

    // csr writes first, trap handling below overrides them
    if (we_i && sel_i.mstatus) begin
      mie_d  = wword_i.mstatus.mie;
      mpie_d = wword_i.mstatus.mpie;
    end
    if (we_i && sel_i.mepc) begin
      mepc_d = wword_i.raw;
    end
    if (we_i && sel_i.mcause) begin
      cause_d = {wword_i.mcause.irq, wword_i.mcause.code};
    end

    if (trap_i.save_cause) begin
      // pc from fetch or decode, decode by default
      mepc_d  = trap_i.save_if ? trap_i.pc_if : trap_i.pc_id;
      cause_d = trap_i.cause;
      mpie_d  = mie_q;
      mie_d   = 1'b0;
    end else if (trap_i.restore_mret) begin
      mie_d  = mpie_q;
      mpie_d = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mie_q   <= 1'b0;
      mpie_q  <= 1'b0;
      mepc_q  <= '0;
      cause_q <= '0;
    end else begin
      mie_q   <= mie_d;
      mpie_q  <= mpie_d;
      mepc_q  <= mepc_d;
      cause_q <= cause_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // architectural views
  ////////////////////////////////////////////////////////////

  always_comb begin
    mstatus_o      = '0;
    mstatus_o.mpp  = PRIV_M;
    mstatus_o.mpie = mpie_q;
    mstatus_o.mie  = mie_q;
  end

  always_comb begin
    mcause_o      = '0;
    mcause_o.irq  = cause_q[5];
    mcause_o.code = cause_q[4:0];
  end

  assign mepc_o       = mepc_q;
  assign epc_o        = mepc_q;
  assign irq_enable_o = mie_q;

  // controller never enters a trap and returns in one cycle
  a_trap_mret_excl: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(trap_i.save_cause && trap_i.restore_mret)
  );

endmodule

/* csr_execute.sv */
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_execute import csr_pkg::*; (
  input  csr_req_t             req_i,
  // current value of the selected register
  input  logic [`CSR_XLEN-1:0] old_i,
  output csr_word_u            wword_o,
  output logic                 we_o
);

  ////////////////////////////////////////////////////////////
  // read-modify-write
  ////////////////////////////////////////////////////////////

  always_comb begin
    // op none falls through with the raw data, strobe stays low
    wword_o.raw = req_i.wdata;
    case (req_i.op)
      CSR_OP_WRITE: begin
        wword_o.raw = req_i.wdata;
      end
      // set selected bits
      CSR_OP_SET: begin
        wword_o.raw = old_i | req_i.wdata;
      end
      // clear selected bits, keep the rest
      CSR_OP_CLEAR: begin
        wword_o.raw = old_i & ~req_i.wdata;
      end
      default: ;
    endcase
  end

  // one write per strobe, no stall path
  assign we_o = req_i.access && (req_i.op != CSR_OP_NONE);

endmodule

/* csr_decode.sv */
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_decode import csr_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  csr_req_t req_i,
  output csr_sel_t sel_o
);

  // upper bits of the counter window base
  localparam logic [`CSR_ADDR_W-1:0] PCCR_BASE = `CSR_ADDR_PCCR_BASE;

  ////////////////////////////////////////////////////////////
  // address compare
  ////////////////////////////////////////////////////////////

  always_comb begin
    sel_o = '0;
    // idle cycles leave every select low
    if (req_i.access) begin
      case (req_i.addr)
        `CSR_ADDR_MSTATUS: sel_o.mstatus = 1'b1;
        `CSR_ADDR_MTVEC:   sel_o.mtvec   = 1'b1;
        `CSR_ADDR_MEPC:    sel_o.mepc    = 1'b1;
        `CSR_ADDR_MCAUSE:  sel_o.mcause  = 1'b1;
        `CSR_ADDR_MHARTID: sel_o.mhartid = 1'b1;
        `CSR_ADDR_PCER:    sel_o.pcer    = 1'b1;
        `CSR_ADDR_PCMR:    sel_o.pcmr    = 1'b1;
        default: ;
      endcase
      // low bits pick one of the counters 0x780..0x787
      if (req_i.addr[`CSR_ADDR_W-1:CSR_PERF_IDX_W] ==
          PCCR_BASE[`CSR_ADDR_W-1:CSR_PERF_IDX_W]) begin
        sel_o.pccr     = 1'b1;
        sel_o.pccr_idx = req_i.addr[CSR_PERF_IDX_W-1:0];
      end
    end
  end

  // the register stages rely on at most one select per strobe
  a_sel_onehot: assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0({sel_o.mstatus, sel_o.mtvec, sel_o.mepc, sel_o.mcause,
              sel_o.mhartid, sel_o.pcer, sel_o.pcmr, sel_o.pccr})
  );

endmodule

/* csr_pkg.sv */
`include "csr_settings.svh"

package csr_pkg;

  // counter index width, 3 for eight counters
  localparam int CSR_PERF_IDX_W = $clog2(`CSR_N_PERF);

  ////////////////////////////////////////////////////////////
  // request side
  ////////////////////////////////////////////////////////////

  // same encoding as the core's csr_op field
  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  typedef struct packed {
    logic                   access;
    logic [`CSR_ADDR_W-1:0] addr;
    csr_op_e                op;
    logic [`CSR_XLEN-1:0]   wdata;
  } csr_req_t;

  // one-hot register select, all zero when idle
  typedef struct packed {
    logic                      mstatus;
    logic                      mtvec;
    logic                      mepc;
    logic                      mcause;
    logic                      mhartid;
    logic                      pcer;
    logic                      pcmr;
    logic                      pccr;
    logic [CSR_PERF_IDX_W-1:0] pccr_idx;
  } csr_sel_t;

  ////////////////////////////////////////////////////////////
  // register layouts
  ////////////////////////////////////////////////////////////

  // architectural mstatus, gaps sized from the bit positions
  typedef struct packed {
    logic [`CSR_XLEN-14:0]                                 rsvd_hi;
    logic [1:0]                                            mpp;
    logic [9-`CSR_MSTATUS_MPIE_BIT:0]                      rsvd_mid;
    logic                                                  mpie;
    logic [`CSR_MSTATUS_MPIE_BIT-`CSR_MSTATUS_MIE_BIT-2:0] rsvd_lo;
    logic                                                  mie;
    logic [`CSR_MSTATUS_MIE_BIT-1:0]                       rsvd_0;
  } mstatus_t;

  typedef struct packed {
    logic                 irq;
    logic [`CSR_XLEN-7:0] rsvd;
    logic [4:0]           code;
  } mcause_t;

  // one write word, read as mstatus or mcause by the target stage
  typedef union packed {
    logic [`CSR_XLEN-1:0] raw;
    mstatus_t             mstatus;
    mcause_t              mcause;
  } csr_word_u;

  // controller side of trap entry and mret
  typedef struct packed {
    logic                 save_cause;
    logic                 save_if;
    logic                 save_id;
    logic                 restore_mret;
    // bit 5 flags an interrupt
    logic [5:0]           cause;
    logic [`CSR_XLEN-1:0] pc_if;
    logic [`CSR_XLEN-1:0] pc_id;
  } trap_ctrl_t;

  typedef struct packed {
    logic id_valid;
    logic is_decoding;
    logic ld_stall;
    logic mem_load;
    logic mem_store;
    logic jump;
    logic branch;
    logic branch_taken;
  } perf_events_t;

  typedef logic [`CSR_N_PERF-1:0][`CSR_XLEN-1:0] pccr_arr_t;

endpackage

/* csr_settings.svh */
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

////////////////////////////////////////////////////////////
// widths
////////////////////////////////////////////////////////////

// data word of every csr
`define CSR_XLEN 32

// address field of a csr instruction
`define CSR_ADDR_W 12

// counters in the perf block
`define CSR_N_PERF 8

////////////////////////////////////////////////////////////
// machine mode addresses
////////////////////////////////////////////////////////////

`define CSR_ADDR_MSTATUS 12'h300
`define CSR_ADDR_MTVEC 12'h305
`define CSR_ADDR_MEPC 12'h341
`define CSR_ADDR_MCAUSE 12'h342
`define CSR_ADDR_MHARTID 12'hF14

// perf block, custom space
`define CSR_ADDR_PCER 12'h7A0
`define CSR_ADDR_PCMR 12'h7A1
// first counter, the rest follow in order
`define CSR_ADDR_PCCR_BASE 12'h780

// mstatus interrupt enable bits
`define CSR_MSTATUS_MIE_BIT 3
`define CSR_MSTATUS_MPIE_BIT 7

`endif
